// ==== tenyr_params.svh ====
`ifndef TENYR_PARAMS_SVH
`define TENYR_PARAMS_SVH

// all addresses are word addresses

// first word fetched after reset, also the base of the block RAM
`define RESET_VECTOR 32'h00001000

// main memory window
`define RAM_MATCH    `RESET_VECTOR
`define RAM_MASK     32'hfffff000

// two display registers at 0x100 and 0x101
`define SEG7_MATCH   32'h00000100
`define SEG7_MASK    32'hfffffffe

// 4096 words fill the RAM window
`define RAM_ABITS    12

// cycles per digit, kept short for simulation
`define SCAN_DIV     16

`endif

// ==== tenyr_pkg.sv ====
package tenyr_pkg;

    // one bus word carries both addresses and data
    typedef logic [31:0] word_t;

    // bit n enables byte lane n of a word
    typedef logic [3:0] sel_t;

    // slave slots behind the data bus decoder
    localparam int NUM_SLAVES = 2;

    typedef enum int unsigned {
        SLV_RAM  = 0,
        SLV_SEG7 = 1
    } slave_e;

    // bytes per bus word
    localparam int WORD_BYTES = $bits(sel_t);

endpackage

// ==== block_ram.sv ====
`timescale 1ns/1ps

module block_ram #(
    parameter int ABITS = 12
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  tenyr_pkg::sel_t  sel_i,
    input  tenyr_pkg::word_t adr_i,
    input  tenyr_pkg::word_t dat_i,
    output tenyr_pkg::word_t dat_o,
    output logic             ack_o
);
    import tenyr_pkg::*;

    word_t            mem [2**ABITS];
    word_t            rd_q;
    logic             ack_q;
    logic             access;
    logic [ABITS-1:0] idx;

    // word index from the low address bits, window base is decoded upstream
    assign idx = adr_i[ABITS-1:0];

    // the held stb of the acking cycle must not start a second access
    assign access = stb_i & ~ack_q;

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (we_i) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (sel_i[b]) begin
                        mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
            rd_q <= mem[idx];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign dat_o = rd_q;
    assign ack_o = ack_q;

endmodule

// ==== seg7_regs.sv ====
`timescale 1ns/1ps

module seg7_regs (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  tenyr_pkg::sel_t  sel_i,
    input  tenyr_pkg::word_t adr_i,
    input  tenyr_pkg::word_t dat_i,
    output tenyr_pkg::word_t dat_o,
    output logic             ack_o,
    output logic [15:0]      digits_o,
    output logic [3:0]       dp_mask_o,
    output logic             disp_en_o
);
    import tenyr_pkg::*;

    logic [15:0] digits_q;
    logic [3:0]  dp_mask_q;
    logic        disp_en_q;
    logic        ack_q;
    logic        access;
    word_t       rd_q;

    assign access = stb_i & ~ack_q;

    // reg 0 holds four hex digits, reg 1 holds dp mask and enable
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            digits_q  <= '0;
            dp_mask_q <= '0;
            disp_en_q <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && we_i) begin
                if (!adr_i[0]) begin
                    if (sel_i[0]) begin
                        digits_q[7:0] <= dat_i[7:0];
                    end
                    if (sel_i[1]) begin
                        digits_q[15:8] <= dat_i[15:8];
                    end
                end else if (sel_i[0]) begin
                    disp_en_q <= dat_i[0];
                    dp_mask_q <= dat_i[7:4];
                end
            end
        end
    end

    // readback, unused bits come back as zero
    always_ff @(posedge clk_i) begin
        if (access) begin
            rd_q <= adr_i[0] ? {24'h0, dp_mask_q, 3'b000, disp_en_q} : {16'h0, digits_q};
        end
    end

    assign dat_o     = rd_q;
    assign ack_o     = ack_q;
    assign digits_o  = digits_q;
    assign dp_mask_o = dp_mask_q;
    assign disp_en_o = disp_en_q;

endmodule

// ==== seg7_scan.sv ====
`timescale 1ns/1ps

module seg7_scan #(
    parameter int DIV = 16
) (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [15:0] digits_i,
    input  logic [3:0]  dp_mask_i,
    input  logic        disp_en_i,
    output logic [7:0]  seg_o,
    output logic [3:0]  an_o
);
    localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] div_cnt;
    logic [1:0]    digit_idx;
    logic [3:0]    nibble;
    logic [7:0]    seg_q;
    logic [3:0]    an_q;

    // active-low glyphs, bit 6 is g and bit 0 is a
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0: hex_to_seg = 7'h40;
            4'h1: hex_to_seg = 7'h79;
            4'h2: hex_to_seg = 7'h24;
            4'h3: hex_to_seg = 7'h30;
            4'h4: hex_to_seg = 7'h19;
            4'h5: hex_to_seg = 7'h12;
            4'h6: hex_to_seg = 7'h02;
            4'h7: hex_to_seg = 7'h78;
            4'h8: hex_to_seg = 7'h00;
            4'h9: hex_to_seg = 7'h10;
            4'ha: hex_to_seg = 7'h08;
            4'hb: hex_to_seg = 7'h03;
            4'hc: hex_to_seg = 7'h46;
            4'hd: hex_to_seg = 7'h21;
            4'he: hex_to_seg = 7'h06;
            default: hex_to_seg = 7'h0e;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // digit rotation, one step every DIV cycles

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt   <= '0;
            digit_idx <= '0;
        end else if (div_cnt == CW'(DIV - 1)) begin
            div_cnt   <= '0;
            digit_idx <= digit_idx + 2'd1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign nibble = digits_i[4*digit_idx +: 4];

    // anode and segments change together, all dark while disabled
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            an_q  <= '1;
            seg_q <= '1;
        end else if (disp_en_i) begin
            an_q  <= ~(4'b0001 << digit_idx);
            seg_q <= {~dp_mask_i[digit_idx], hex_to_seg(nibble)};
        end else begin
            an_q  <= '1;
            seg_q <= '1;
        end
    end

    assign an_o  = an_q;
    assign seg_o = seg_q;

endmodule

// ==== wb_mux.sv ====
`timescale 1ns/1ps
`include "tenyr_params.svh"

module wb_mux #(
    parameter tenyr_pkg::word_t MATCH_ADDR [tenyr_pkg::NUM_SLAVES] = '{
        tenyr_pkg::SLV_RAM:  `RAM_MATCH,
        tenyr_pkg::SLV_SEG7: `SEG7_MATCH
    },
    parameter tenyr_pkg::word_t MATCH_MASK [tenyr_pkg::NUM_SLAVES] = '{
        tenyr_pkg::SLV_RAM:  `RAM_MASK,
        tenyr_pkg::SLV_SEG7: `SEG7_MASK
    }
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    // master side
    input  tenyr_pkg::word_t wbm_adr_i,
    input  tenyr_pkg::word_t wbm_dat_i,
    input  logic             wbm_we_i,
    input  tenyr_pkg::sel_t  wbm_sel_i,
    input  logic             wbm_stb_i,
    input  logic             wbm_cyc_i,
    output tenyr_pkg::word_t wbm_dat_o,
    output logic             wbm_ack_o,
    output logic             wbm_err_o,
    // request lines shared by all slaves
    output tenyr_pkg::word_t wbs_adr_o,
    output tenyr_pkg::word_t wbs_dat_o,
    output logic             wbs_we_o,
    output tenyr_pkg::sel_t  wbs_sel_o,
    // per-slave lines
    output logic             wbs_stb_o [tenyr_pkg::NUM_SLAVES],
    input  logic             wbs_ack_i [tenyr_pkg::NUM_SLAVES],
    input  tenyr_pkg::word_t wbs_dat_i [tenyr_pkg::NUM_SLAVES]
);
    import tenyr_pkg::*;

    logic [NUM_SLAVES-1:0] hit;
    logic [NUM_SLAVES-1:0] grant;
    logic                  unmapped;
    logic                  err_q;

    ////////////////////////////////////////////////////////////
    // address decode

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            hit[i] = (wbm_adr_i & MATCH_MASK[i]) == MATCH_ADDR[i];
        end
    end

    // isolate the lowest set bit, so the lower index wins on overlap
    assign grant = hit & (~hit + 1'b1);

    assign unmapped = wbm_stb_i & wbm_cyc_i & ~|hit;

    ////////////////////////////////////////////////////////////
    // request fan-out

    assign wbs_adr_o = wbm_adr_i;
    assign wbs_dat_o = wbm_dat_i;
    assign wbs_we_o  = wbm_we_i;
    assign wbs_sel_o = wbm_sel_i;

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            wbs_stb_o[i] = grant[i] & wbm_stb_i & wbm_cyc_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // response path

    // only the granted slave ever acks, so its data is taken as is
    always_comb begin
        wbm_ack_o = 1'b0;
        wbm_dat_o = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (wbs_ack_i[i]) begin
                wbm_ack_o = 1'b1;
                wbm_dat_o = wbs_dat_i[i];
            end
        end
    end

    // unmapped access: one-cycle err pulse, read data stays zero
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= unmapped & ~err_q;
        end
    end

    assign wbm_err_o = err_q;

endmodule

// ==== tenyr_soc.sv ====
`timescale 1ns/1ps
`include "tenyr_params.svh"

module tenyr_soc (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  tenyr_pkg::word_t wbm_adr_i,
    input  tenyr_pkg::word_t wbm_dat_i,
    input  logic             wbm_we_i,
    input  tenyr_pkg::sel_t  wbm_sel_i,
    input  logic             wbm_stb_i,
    input  logic             wbm_cyc_i,
    output tenyr_pkg::word_t wbm_dat_o,
    output logic             wbm_ack_o,
    output logic             wbm_err_o,
    output logic [7:0]       seg_o,
    output logic [3:0]       an_o
);
    import tenyr_pkg::*;

    // request lines fanned out by the decoder
    word_t bus_adr;
    word_t bus_dat;
    logic  bus_we;
    sel_t  bus_sel;

    // per-slave strobe, ack and read data, indexed by slave_e
    logic  slv_stb [NUM_SLAVES];
    wire   slv_ack [NUM_SLAVES];
    wire word_t slv_dat [NUM_SLAVES];

    logic [15:0] digits;
    logic [3:0]  dp_mask;
    logic        disp_en;

    ////////////////////////////////////////////////////////////
    // bus decoder

    wb_mux u_mux (
        .clk_i     (clk_i),     .arst_n_i  (arst_n_i),
        .wbm_adr_i (wbm_adr_i), .wbm_dat_i (wbm_dat_i),
        .wbm_we_i  (wbm_we_i),  .wbm_sel_i (wbm_sel_i),
        .wbm_stb_i (wbm_stb_i), .wbm_cyc_i (wbm_cyc_i),
        .wbm_dat_o (wbm_dat_o), .wbm_ack_o (wbm_ack_o), .wbm_err_o (wbm_err_o),
        .wbs_adr_o (bus_adr),   .wbs_dat_o (bus_dat),
        .wbs_we_o  (bus_we),    .wbs_sel_o (bus_sel),
        .wbs_stb_o (slv_stb),   .wbs_ack_i (slv_ack),   .wbs_dat_i (slv_dat)
    );

    ////////////////////////////////////////////////////////////
    // memory and display

    block_ram #(.ABITS(`RAM_ABITS)) u_ram (
        .clk_i (clk_i),             .arst_n_i (arst_n_i),
        .stb_i (slv_stb[SLV_RAM]),  .we_i     (bus_we),   .sel_i (bus_sel),
        .adr_i (bus_adr),           .dat_i    (bus_dat),
        .dat_o (slv_dat[SLV_RAM]),  .ack_o    (slv_ack[SLV_RAM])
    );

    seg7_regs u_seg7_regs (
        .clk_i    (clk_i),             .arst_n_i  (arst_n_i),
        .stb_i    (slv_stb[SLV_SEG7]), .we_i      (bus_we),   .sel_i (bus_sel),
        .adr_i    (bus_adr),           .dat_i     (bus_dat),
        .dat_o    (slv_dat[SLV_SEG7]), .ack_o     (slv_ack[SLV_SEG7]),
        .digits_o (digits),            .dp_mask_o (dp_mask),  .disp_en_o (disp_en)
    );

    seg7_scan #(.DIV(`SCAN_DIV)) u_seg7_scan (
        .clk_i     (clk_i),   .arst_n_i  (arst_n_i),
        .digits_i  (digits),  .dp_mask_i (dp_mask), .disp_en_i (disp_en),
        .seg_o     (seg_o),   .an_o      (an_o)
    );

endmodule

// ==== tb_tenyr_soc.sv ====
`timescale 1ns/1ps
`include "tenyr_params.svh"

module tb_tenyr_soc;
    import tenyr_pkg::*;

    localparam int BUS_TIMEOUT = 20;
    localparam int SCAN_WAIT   = 5 * `SCAN_DIV;
    localparam int STEP_WAIT   = `SCAN_DIV + 1;
    // active-high gfedcba glyphs with digit f in the top slice and digit 0 at the bottom
    localparam logic [16*7-1:0] GLYPHS = {7'h71, 7'h79, 7'h5e, 7'h39, 7'h7c, 7'h77, 7'h6f,
        7'h7f, 7'h07, 7'h7d, 7'h6d, 7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f};

    logic       clk_i, arst_n_i, wbm_we_i, wbm_stb_i, wbm_cyc_i, wbm_ack_o, wbm_err_o;
    word_t      wbm_adr_i, wbm_dat_i, wbm_dat_o;
    sel_t       wbm_sel_i;
    logic [7:0] seg_o;
    logic [3:0] an_o;
    integer     seed = 32'h6f0982bb;
    word_t      ram_model [2**`RAM_ABITS];

    tenyr_soc UUT (
        .clk_i (clk_i), .arst_n_i (arst_n_i), .wbm_adr_i (wbm_adr_i), .wbm_dat_i (wbm_dat_i),
        .wbm_we_i (wbm_we_i), .wbm_sel_i (wbm_sel_i), .wbm_stb_i (wbm_stb_i),
        .wbm_cyc_i (wbm_cyc_i), .wbm_dat_o (wbm_dat_o), .wbm_ack_o (wbm_ack_o),
        .wbm_err_o (wbm_err_o), .seg_o (seg_o), .an_o (an_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else abort_run($sformatf("FAIL at %0t ns: %s read %h, expected %h",
            $time, what, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // bus protocol checks

    resp_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wbm_ack_o || wbm_err_o) |=> !(wbm_ack_o || wbm_err_o))
        else abort_run($sformatf("FAIL at %0t ns: response held for two cycles", $time));
    resp_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(wbm_ack_o && wbm_err_o))
        else abort_run($sformatf("FAIL at %0t ns: ack and err high together", $time));
    resp_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(wbm_stb_i) |=> (wbm_ack_o || wbm_err_o))
        else abort_run($sformatf("FAIL at %0t ns: no response one cycle after stb", $time));
    err_no_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wbm_err_o |-> (wbm_dat_o == '0))
        else abort_run($sformatf("FAIL at %0t ns: err with nonzero read data", $time));
    anode_shape: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (an_o == 4'hf) || $onehot(~an_o))
        else abort_run($sformatf("FAIL at %0t ns: an_o %b drives several digits", $time, an_o));

    ////////////////////////////////////////////////////////////
    // bus master

    task automatic run_access(input word_t adr, input word_t wdat, input logic we,
                              input sel_t sel, input logic expect_err, output word_t rdat);
        int waited;
        waited = 0;
        @(posedge clk_i);
        wbm_adr_i <= adr;
        wbm_dat_i <= wdat;
        wbm_we_i  <= we;
        wbm_sel_i <= sel;
        wbm_stb_i <= 1'b1;
        wbm_cyc_i <= 1'b1;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!(wbm_ack_o || wbm_err_o) && waited < BUS_TIMEOUT);
        if (!(wbm_ack_o || wbm_err_o)) begin
            abort_run($sformatf("bus %s at address %h got neither ack nor err in %0d cycles",
                we ? "write" : "read", adr, BUS_TIMEOUT));
        end
        rdat = wbm_dat_o;
        assert (wbm_err_o == expect_err && wbm_ack_o == !expect_err) else abort_run($sformatf(
            "FAIL at %0t ns: address %h gave ack %b err %b", $time, adr, wbm_ack_o, wbm_err_o));
        // stb is seen one edge after it is driven and the response shows at the next edge
        assert (waited == 2) else abort_run($sformatf(
            "FAIL at %0t ns: address %h answered after %0d edges", $time, adr, waited));
        wbm_stb_i <= 1'b0;
        wbm_cyc_i <= 1'b0;
        wbm_we_i  <= 1'b0;
    endtask

    task automatic bus_write(input word_t adr, input word_t wdat, input sel_t sel,
                             input logic expect_err);
        word_t unused;
        run_access(adr, wdat, 1'b1, sel, expect_err, unused);
    endtask

    task automatic bus_read(input word_t adr, input logic expect_err, output word_t rdat);
        run_access(adr, '0, 1'b0, 4'hf, expect_err, rdat);
    endtask

    task automatic wait_for_anode(input logic [3:0] pattern, input int limit);
        int waited;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (an_o !== pattern && waited < limit);
        if (an_o !== pattern) begin
            abort_run($sformatf("an_o never showed %b within %0d cycles", pattern, limit));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        word_t      addr_list [16];
        word_t      rdat, wdat, digits_val, ctrl_val, probe_val;
        logic [3:0] dp_val;
        logic [7:0] exp_seg;
        int         idx;

        arst_n_i  = 1'b0;
        wbm_adr_i = '0;
        wbm_dat_i = '0;
        wbm_we_i  = 1'b0;
        wbm_sel_i = '0;
        wbm_stb_i = 1'b0;
        wbm_cyc_i = 1'b0;
        repeat (8) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        assert (an_o == 4'hf && seg_o == 8'hff) else abort_run($sformatf(
            "FAIL at %0t ns: display not dark after reset, an %b seg %h", $time, an_o, seg_o));

        // random full words across the RAM window
        for (int i = 0; i < 16; i++) begin
            addr_list[i] = `RESET_VECTOR | (word_t'($random(seed)) & 32'h0000_0fff);
            wdat = $random(seed);
            ram_model[addr_list[i][`RAM_ABITS-1:0]] = wdat;
            bus_write(addr_list[i], wdat, 4'hf, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(addr_list[i], 1'b0, rdat);
            compare_word("RAM word", rdat, ram_model[addr_list[i][`RAM_ABITS-1:0]]);
        end

        // only byte 2 may change
        idx  = addr_list[0][`RAM_ABITS-1:0];
        wdat = $random(seed);
        ram_model[idx] = (ram_model[idx] & 32'hff00_ffff) | (wdat & 32'h00ff_0000);
        bus_write(addr_list[0], wdat, 4'b0100, 1'b0);
        bus_read(addr_list[0], 1'b0, rdat);
        compare_word("byte-lane write", rdat, ram_model[idx]);

        // display registers
        bus_read(`SEG7_MATCH, 1'b0, rdat);
        compare_word("digits after reset", rdat, '0);
        bus_read(`SEG7_MATCH + 1, 1'b0, rdat);
        compare_word("control after reset", rdat, '0);
        digits_val = $random(seed);
        ctrl_val   = $random(seed) | 32'h1;
        bus_write(`SEG7_MATCH, digits_val, 4'hf, 1'b0);
        bus_write(`SEG7_MATCH + 1, ctrl_val, 4'hf, 1'b0);
        bus_read(`SEG7_MATCH, 1'b0, rdat);
        compare_word("digits", rdat, digits_val & 32'h0000_ffff);
        bus_read(`SEG7_MATCH + 1, 1'b0, rdat);
        compare_word("control", rdat, ctrl_val & 32'h0000_00f1);
        dp_val = ctrl_val[7:4];

        // scan through the four digits in order, one step per divider period
        for (int pos = 0; pos < 4; pos++) begin
            wait_for_anode(4'b1111 ^ (4'b0001 << pos), (pos == 0) ? SCAN_WAIT : STEP_WAIT);
            exp_seg = {~dp_val[pos], ~GLYPHS[7*digits_val[4*pos +: 4] +: 7]};
            assert (seg_o == exp_seg) else abort_run($sformatf(
                "FAIL at %0t ns: digit %0d seg_o %h, expected %h", $time, pos, seg_o, exp_seg));
        end
        bus_write(`SEG7_MATCH + 1, 32'h0, 4'hf, 1'b0);
        repeat (8 * `SCAN_DIV) begin
            @(posedge clk_i);
            assert (an_o == 4'hf) else abort_run($sformatf(
                "FAIL at %0t ns: an_o %b while display disabled", $time, an_o));
        end

        // unmapped hole must not touch RAM or display
        probe_val = $random(seed);
        bus_write(`RESET_VECTOR + 32'h200, probe_val, 4'hf, 1'b0);
        bus_write(32'h0000_0200, ~probe_val, 4'hf, 1'b1);
        bus_write(32'h0000_0201, 32'hffff_ffff, 4'hf, 1'b1);
        bus_read(32'h0000_0200, 1'b1, rdat);
        bus_read(`RESET_VECTOR + 32'h200, 1'b0, rdat);
        compare_word("RAM after unmapped write", rdat, probe_val);
        bus_read(`SEG7_MATCH, 1'b0, rdat);
        compare_word("digits after unmapped write", rdat, digits_val & 32'h0000_ffff);
        bus_read(`SEG7_MATCH + 1, 1'b0, rdat);
        compare_word("control after unmapped write", rdat, '0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
tenyr_pkg.sv
block_ram.sv
seg7_regs.sv
seg7_scan.sv
wb_mux.sv
tenyr_soc.sv
tb_tenyr_soc.sv
